// ==== source/glb_param_pkg.sv ====
/*
 * global buffer parallel-config parameters
 *   bank geometry and read latency
 *   dma word count width and done delay
 *   cgra configuration register sizes
 */
`default_nettype none

package glb_param_pkg;

    // bank word geometry
    localparam int BANK_DATA_WIDTH = 64;
    // byte step between consecutive words
    localparam int BANK_DATA_BYTE = BANK_DATA_WIDTH / 8;
    // low address bits dropped to get a word index
    localparam int BANK_BYTE_OFFSET = $clog2(BANK_DATA_BYTE);

    // byte address, wraps modulo 2048
    localparam int GLB_ADDR_WIDTH = 11;
    // 256 words per bank
    localparam int BANK_DEPTH = (1 << GLB_ADDR_WIDTH) / BANK_DATA_BYTE;

    // request registered to data valid
    localparam int BANK_RD_LATENCY = 2;

    // dma word count
    localparam int MAX_NUM_CFGS_WIDTH = 8;

    // cgra configuration registers
    localparam int CGRA_CFG_ADDR_WIDTH = 8;
    localparam int CGRA_CFG_DATA_WIDTH = 32;
    localparam int CGRA_CFG_NUM_REGS = 1 << CGRA_CFG_ADDR_WIDTH;

    // end of count to pc_done_pulse
    // covers bank latency plus the response register
    localparam int DONE_DELAY = BANK_RD_LATENCY + 1;

endpackage

`default_nettype wire

// ==== source/glb_packet_pkg.sv ====
/*
 * global buffer packet types
 *   dma_pc_header_t  run header of the pc dma
 *   wr_packet_t      bank load
 *   rdrq_packet_t    bank read request
 *   rdrs_packet_t    bank read response
 *   cgra_cfg_t       one configuration write
 */
`default_nettype none

package glb_packet_pkg;

    // start byte address and word count of one run
    typedef struct packed {
        logic [glb_param_pkg::GLB_ADDR_WIDTH-1:0]     start_addr;
        logic [glb_param_pkg::MAX_NUM_CFGS_WIDTH-1:0] num_cfgs;
    } dma_pc_header_t;

    // bank load, byte addressed
    typedef struct packed {
        logic                                      wr_en;
        logic [glb_param_pkg::GLB_ADDR_WIDTH-1:0]  wr_addr;
        logic [glb_param_pkg::BANK_DATA_WIDTH-1:0] wr_data;
    } wr_packet_t;

    // read request, one per cycle while rd_en is high
    typedef struct packed {
        logic                                     rd_en;
        logic [glb_param_pkg::GLB_ADDR_WIDTH-1:0] rd_addr;
    } rdrq_packet_t;

    // read response, data only meaningful with valid
    typedef struct packed {
        logic [glb_param_pkg::BANK_DATA_WIDTH-1:0] rd_data;
        logic                                      rd_data_valid;
    } rdrs_packet_t;

    // configuration write into the cgra register file
    // bank word bits 31:0 are the data, bits 39:32 the address
    typedef struct packed {
        logic                                          cfg_wr_en;
        logic [glb_param_pkg::CGRA_CFG_ADDR_WIDTH-1:0] cfg_addr;
        logic [glb_param_pkg::CGRA_CFG_DATA_WIDTH-1:0] cfg_data;
    } cgra_cfg_t;

endpackage

`default_nettype wire

// ==== source/glb_shift.sv ====
/*
 * glb_shift
 *   fixed-depth register delay line
 *   payload type given by parameter, cleared by reset
 */
`timescale 1ns/100ps
`default_nettype none

module glb_shift #(
    parameter type data_t = logic,
    parameter int  depth  = 1
) (
    input  logic  clk,
    input  logic  reset,
    input  logic  clk_en,
    input  data_t data_in,
    output data_t data_out
);

    // one register per stage
    data_t pipe [depth];

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < depth; i++) begin
                pipe[i] <= '0;
            end
        end else if (clk_en) begin
            // head of the chain
            pipe[0] <= data_in;
            // remaining stages move one step
            for (int i = 1; i < depth; i++) begin
                pipe[i] <= pipe[i-1];
            end
        end
    end

    // tail of the chain, depth cycles after data_in
    assign data_out = pipe[depth-1];

endmodule

`default_nettype wire

// ==== source/glb_bank.sv ====
/*
 * glb_bank
 *   single-port-per-direction bank memory
 *   write port from wr_packet, byte address to word index
 *   read port with a fixed latency of BANK_RD_LATENCY
 */
`timescale 1ns/100ps
`default_nettype none

module glb_bank (
    input  logic                        clk,
    input  logic                        reset,

    // bank load
    input  glb_packet_pkg::wr_packet_t   wr_packet,

    // read request and response
    input  glb_packet_pkg::rdrq_packet_t rdrq_packet,
    output glb_packet_pkg::rdrs_packet_t rdrs_packet
);

    // word storage
    logic [glb_param_pkg::BANK_DATA_WIDTH-1:0] mem [glb_param_pkg::BANK_DEPTH];

    // first read stage
    logic [glb_param_pkg::BANK_DATA_WIDTH-1:0] rd_data_q;
    logic                                      rd_valid_q;
    glb_packet_pkg::rdrs_packet_t              rdrs_stage;

    // word indices, low byte bits dropped
    logic [glb_param_pkg::GLB_ADDR_WIDTH-glb_param_pkg::BANK_BYTE_OFFSET-1:0] wr_idx;
    logic [glb_param_pkg::GLB_ADDR_WIDTH-glb_param_pkg::BANK_BYTE_OFFSET-1:0] rd_idx;

    assign wr_idx = wr_packet.wr_addr[glb_param_pkg::GLB_ADDR_WIDTH-1:
                                      glb_param_pkg::BANK_BYTE_OFFSET];
    assign rd_idx = rdrq_packet.rd_addr[glb_param_pkg::GLB_ADDR_WIDTH-1:
                                        glb_param_pkg::BANK_BYTE_OFFSET];

    // write port
    always_ff @(posedge clk) begin
        if (wr_packet.wr_en) begin
            mem[wr_idx] <= wr_packet.wr_data;
        end
    end

    // read data, sees the word from before a same-cycle write
    always_ff @(posedge clk) begin
        if (rdrq_packet.rd_en) begin
            rd_data_q <= mem[rd_idx];
        end
    end

    // read valid
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            rd_valid_q <= 1'b0;
        end else begin
            rd_valid_q <= rdrq_packet.rd_en;
        end
    end

    assign rdrs_stage.rd_data       = rd_data_q;
    assign rdrs_stage.rd_data_valid = rd_valid_q;

    // remaining latency after the first stage
    glb_shift #(
        .data_t (glb_packet_pkg::rdrs_packet_t),
        .depth  (glb_param_pkg::BANK_RD_LATENCY - 1)
    ) u_rdrs_shift (
        .clk      (clk),
        .reset    (reset),
        .clk_en   (1'b1),
        .data_in  (rdrs_stage),
        .data_out (rdrs_packet)
    );

endmodule

`default_nettype wire

// ==== source/glb_pc_dma.sv ====
/*
 * glb_pc_dma
 *   parallel-configuration dma
 *   start handshake, address walk and read requests
 *   response register split into configuration writes
 *   done pulse through a fixed delay line
 */
`timescale 1ns/100ps
`default_nettype none

module glb_pc_dma (
    input  logic                           clk,
    input  logic                           reset,

    // configuration write toward the array
    output glb_packet_pkg::cgra_cfg_t      cgra_cfg_c2sw,

    // bank read path
    output glb_packet_pkg::rdrq_packet_t   rdrq_packet,
    input  glb_packet_pkg::rdrs_packet_t   rdrs_packet,

    // run setup
    input  logic                           cfg_pc_dma_mode,
    input  glb_packet_pkg::dma_pc_header_t cfg_pc_dma_header,

    // start and done pulses
    input  logic                           pc_start_pulse,
    output logic                           pc_done_pulse
);

    // start handshake
    logic start_q;
    logic start_internal;

    // run state
    logic                                         pc_run;
    logic [glb_param_pkg::MAX_NUM_CFGS_WIDTH-1:0] cfg_cnt;
    logic [glb_param_pkg::GLB_ADDR_WIDTH-1:0]     addr;
    logic                                         end_of_count;
    logic                                         done_internal;

    // registered read request
    logic                                     rd_en_q;
    logic [glb_param_pkg::GLB_ADDR_WIDTH-1:0] rd_addr_q;

    // registered read response
    logic [glb_param_pkg::BANK_DATA_WIDTH-1:0] rd_data_q;
    logic                                      rd_valid_q;

    // running with nothing left to request
    assign end_of_count = pc_run && (cfg_cnt == '0);

    // edge 0 samples the pulse with its mode
    // edge 1 accepts it unless a run is pending or active
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            start_q        <= 1'b0;
            start_internal <= 1'b0;
        end else begin
            start_q        <= pc_start_pulse && cfg_pc_dma_mode;
            start_internal <= start_q && !pc_run && !start_internal;
        end
    end

    // run flag, set by the accepted start, cleared after the last request
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            pc_run <= 1'b0;
        end else if (start_internal) begin
            pc_run <= 1'b1;
        end else if (end_of_count) begin
            pc_run <= 1'b0;
        end
    end

    // down-counter and byte address
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            cfg_cnt <= '0;
            addr    <= '0;
        end else if (start_internal) begin
            cfg_cnt <= cfg_pc_dma_header.num_cfgs;
            addr    <= cfg_pc_dma_header.start_addr;
        end else if (pc_run && (cfg_cnt != '0)) begin
            cfg_cnt <= cfg_cnt - 1'b1;
            // wraps at the end of the bank
            addr    <= addr + glb_param_pkg::GLB_ADDR_WIDTH'(glb_param_pkg::BANK_DATA_BYTE);
        end
    end

    // one read per cycle while words remain
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            rd_en_q <= 1'b0;
        end else begin
            rd_en_q <= pc_run && (cfg_cnt != '0);
        end
    end

    always_ff @(posedge clk) begin
        if (pc_run && (cfg_cnt != '0)) begin
            rd_addr_q <= addr;
        end
    end

    assign rdrq_packet.rd_en   = rd_en_q;
    assign rdrq_packet.rd_addr = rd_addr_q;

    // response register
    // only one dma on the bank, so valid alone marks our words
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            rd_valid_q <= 1'b0;
        end else begin
            rd_valid_q <= rdrs_packet.rd_data_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (rdrs_packet.rd_data_valid) begin
            rd_data_q <= rdrs_packet.rd_data;
        end
    end

    // word split into register address and data
    assign cgra_cfg_c2sw.cfg_wr_en = rd_valid_q;
    assign cgra_cfg_c2sw.cfg_addr  =
        rd_data_q[glb_param_pkg::CGRA_CFG_DATA_WIDTH +: glb_param_pkg::CGRA_CFG_ADDR_WIDTH];
    assign cgra_cfg_c2sw.cfg_data  = rd_data_q[0 +: glb_param_pkg::CGRA_CFG_DATA_WIDTH];

    // end-of-count pulse, one cycle at run flag clear
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            done_internal <= 1'b0;
        end else begin
            done_internal <= end_of_count;
        end
    end

    // lands one cycle after the last write
    glb_shift #(
        .data_t (logic),
        .depth  (glb_param_pkg::DONE_DELAY)
    ) u_done_shift (
        .clk      (clk),
        .reset    (reset),
        .clk_en   (1'b1),
        .data_in  (done_internal),
        .data_out (pc_done_pulse)
    );

endmodule

`default_nettype wire

// ==== source/cgra_cfg_reg_file.sv ====
/*
 * cgra_cfg_reg_file
 *   configuration registers of the array
 *   written by cgra_cfg_t writes on the clock edge
 *   combinational readback by address
 */
`timescale 1ns/100ps
`default_nettype none

module cgra_cfg_reg_file (
    input  logic                                          clk,
    input  logic                                          reset,

    // write from the pc dma
    input  glb_packet_pkg::cgra_cfg_t                     cgra_cfg,

    // readback port
    input  logic [glb_param_pkg::CGRA_CFG_ADDR_WIDTH-1:0] cfg_rd_addr,
    output logic [glb_param_pkg::CGRA_CFG_DATA_WIDTH-1:0] cfg_rd_data
);

    // register array, all zero after reset
    logic [glb_param_pkg::CGRA_CFG_DATA_WIDTH-1:0] cfg_regs [glb_param_pkg::CGRA_CFG_NUM_REGS];

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < glb_param_pkg::CGRA_CFG_NUM_REGS; i++) begin
                cfg_regs[i] <= '0;
            end
        end else if (cgra_cfg.cfg_wr_en) begin
            // always accepted, no back-pressure
            cfg_regs[cgra_cfg.cfg_addr] <= cgra_cfg.cfg_data;
        end
    end

    // readback, no register on the path
    assign cfg_rd_data = cfg_regs[cfg_rd_addr];

endmodule

`default_nettype wire

// ==== source/glb_pc_top.sv ====
/*
 * glb_pc_top
 *   global buffer parallel-config path
 *   bank, pc dma and cgra configuration register file
 */
`timescale 1ns/100ps
`default_nettype none

module glb_pc_top (
    input  logic                                          clk,
    input  logic                                          reset,

    // bank load
    input  glb_packet_pkg::wr_packet_t                    wr_packet,

    // dma setup and pulses
    input  logic                                          cfg_pc_dma_mode,
    input  glb_packet_pkg::dma_pc_header_t                cfg_pc_dma_header,
    input  logic                                          pc_start_pulse,
    output logic                                          pc_done_pulse,

    // configuration writes, also seen by the register file
    output glb_packet_pkg::cgra_cfg_t                     cgra_cfg_mon,

    // register file readback
    input  logic [glb_param_pkg::CGRA_CFG_ADDR_WIDTH-1:0] cfg_rd_addr,
    output logic [glb_param_pkg::CGRA_CFG_DATA_WIDTH-1:0] cfg_rd_data
);

    // dma to bank and back
    glb_packet_pkg::rdrq_packet_t rdrq_packet;
    glb_packet_pkg::rdrs_packet_t rdrs_packet;

    // producer
    glb_bank u_bank (
        .clk         (clk),
        .reset       (reset),
        .wr_packet   (wr_packet),
        .rdrq_packet (rdrq_packet),
        .rdrs_packet (rdrs_packet)
    );

    // address walk and word repacking
    glb_pc_dma u_pc_dma (
        .clk               (clk),
        .reset             (reset),
        .cgra_cfg_c2sw     (cgra_cfg_mon),
        .rdrq_packet       (rdrq_packet),
        .rdrs_packet       (rdrs_packet),
        .cfg_pc_dma_mode   (cfg_pc_dma_mode),
        .cfg_pc_dma_header (cfg_pc_dma_header),
        .pc_start_pulse    (pc_start_pulse),
        .pc_done_pulse     (pc_done_pulse)
    );

    // consumer
    cgra_cfg_reg_file u_cfg_reg_file (
        .clk         (clk),
        .reset       (reset),
        .cgra_cfg    (cgra_cfg_mon),
        .cfg_rd_addr (cfg_rd_addr),
        .cfg_rd_data (cfg_rd_data)
    );

endmodule

`default_nettype wire

// ==== testbench/pc_checker.sv ====
/*
 * pc_checker
 *   bank mirror built from the load port
 *   start acceptance and timing model of the pc dma
 *   expected write and done queues, register file model
 *   error and check counters
 */
`timescale 1ns/100ps
`default_nettype none

module pc_checker (
    input  logic                                          clk,
    input  logic                                          reset,
    input  glb_packet_pkg::wr_packet_t                    wr_packet,
    input  logic                                          cfg_pc_dma_mode,
    input  glb_packet_pkg::dma_pc_header_t                cfg_pc_dma_header,
    input  logic                                          pc_start_pulse,
    input  logic                                          pc_done_pulse,
    input  glb_packet_pkg::cgra_cfg_t                     cgra_cfg_mon,
    input  logic [glb_param_pkg::CGRA_CFG_ADDR_WIDTH-1:0] cfg_rd_addr,
    input  logic [glb_param_pkg::CGRA_CFG_DATA_WIDTH-1:0] cfg_rd_data,
    output int                                            error_count,
    output int                                            check_count
);

    // write k shows after edge k+6, seen here at the following edge
    localparam int WRITE_LAG = 7;
    localparam int WORD_IDX_W = glb_param_pkg::GLB_ADDR_WIDTH - 3;

    logic [63:0] bank_model [glb_param_pkg::BANK_DEPTH];
    logic [31:0] reg_model [glb_param_pkg::CGRA_CFG_NUM_REGS];

    // expected writes and done pulses, each with its due edge
    glb_packet_pkg::cgra_cfg_t exp_wr_q [$];
    int                        exp_wr_due_q [$];
    int                        done_due_q [$];

    int   cyc;
    // last start edge that the running transfer still blocks
    int   busy_until;

    task automatic report_mismatch(input string name, input logic [63:0] expected,
                                   input logic [63:0] actual);
        $display("FAIL %0t %s expected %h got %h", $time, name, expected, actual);
        error_count++;
    endtask

    task automatic report_error(input string what);
        $display("ERROR at %0t: %s", $time, what);
        error_count++;
    endtask

    always @(posedge clk) begin : model_step
        glb_packet_pkg::cgra_cfg_t exp_wr;
        logic [WORD_IDX_W-1:0]     idx;
        int                        n;
        int                        base;
        if (reset) begin
            for (int i = 0; i < glb_param_pkg::BANK_DEPTH; i++) begin
                bank_model[i] = '0;
            end
            for (int i = 0; i < glb_param_pkg::CGRA_CFG_NUM_REGS; i++) begin
                reg_model[i] = '0;
            end
            exp_wr_q.delete();
            exp_wr_due_q.delete();
            done_due_q.delete();
            cyc         = 0;
            busy_until  = -1;
            error_count = 0;
            check_count = 0;
        end else begin
            // readback sees registers from before this edge
            check_count++;
            if (cfg_rd_data !== reg_model[cfg_rd_addr]) begin
                report_mismatch("cfg_rd_data", 64'(reg_model[cfg_rd_addr]), 64'(cfg_rd_data));
            end
            // configuration writes, in order and without gaps
            if (exp_wr_due_q.size() > 0 && exp_wr_due_q[0] == cyc) begin
                exp_wr = exp_wr_q.pop_front();
                void'(exp_wr_due_q.pop_front());
                check_count++;
                if (cgra_cfg_mon.cfg_wr_en !== 1'b1) begin
                    report_error("configuration write missing at its cycle");
                end else begin
                    if (cgra_cfg_mon.cfg_addr !== exp_wr.cfg_addr) begin
                        report_mismatch("cgra_cfg_mon.cfg_addr", 64'(exp_wr.cfg_addr),
                                        64'(cgra_cfg_mon.cfg_addr));
                    end
                    if (cgra_cfg_mon.cfg_data !== exp_wr.cfg_data) begin
                        report_mismatch("cgra_cfg_mon.cfg_data", 64'(exp_wr.cfg_data),
                                        64'(cgra_cfg_mon.cfg_data));
                    end
                end
                reg_model[exp_wr.cfg_addr] = exp_wr.cfg_data;
            end else if (cgra_cfg_mon.cfg_wr_en !== 1'b0) begin
                report_error("configuration write appeared with none expected");
            end
            // done pulse, exactly one cycle per accepted run
            if (done_due_q.size() > 0 && done_due_q[0] == cyc) begin
                void'(done_due_q.pop_front());
                check_count++;
                if (pc_done_pulse !== 1'b1) begin
                    report_error("pc_done_pulse missing at its cycle");
                end
            end else if (pc_done_pulse !== 1'b0) begin
                report_error("pc_done_pulse high with no run ending");
            end
            // bank mirror, low 3 address bits dropped
            if (wr_packet.wr_en) begin
                idx = WORD_IDX_W'(int'(wr_packet.wr_addr) / 8);
                bank_model[idx] = wr_packet.wr_data;
            end
            // accepted start queues every write of the run
            if (pc_start_pulse && cfg_pc_dma_mode && cyc > busy_until) begin
                n    = int'(cfg_pc_dma_header.num_cfgs);
                base = int'(cfg_pc_dma_header.start_addr) / 8;
                for (int k = 0; k < n; k++) begin
                    idx              = WORD_IDX_W'((base + k) % glb_param_pkg::BANK_DEPTH);
                    exp_wr.cfg_wr_en = 1'b1;
                    exp_wr.cfg_addr  = bank_model[idx][39:32];
                    exp_wr.cfg_data  = bank_model[idx][31:0];
                    exp_wr_q.push_back(exp_wr);
                    exp_wr_due_q.push_back(cyc + k + WRITE_LAG);
                end
                done_due_q.push_back(cyc + n + WRITE_LAG);
                // run flag clears at edge n+3
                busy_until = cyc + n + 2;
            end
            cyc++;
        end
    end

endmodule

`default_nettype wire

// ==== testbench/tb_glb_pc.sv ====
/*
 * tb_glb_pc
 *   clock, reset and watchdog
 *   xorshift stimulus: bank load, transfers, register readback
 *   dut instance and checker
 */
`timescale 1ns/100ps
`default_nettype none

module tb_glb_pc;

    localparam int CLK_PERIOD   = 8;
    localparam int RESET_CYCLES = 10;
    localparam int NUM_XFERS    = 20;
    localparam int MAX_CNT      = 40;
    // cycles budgeted per transfer on top of its count
    localparam int XFER_SLACK   = 20;
    localparam int QUIET_CYCLES = 16;
    localparam int WATCHDOG_CYCLES = NUM_XFERS * (MAX_CNT + XFER_SLACK)
                                     + 2 * glb_param_pkg::BANK_DEPTH + RESET_CYCLES + 20;

    logic                                          clk = 1'b0;
    logic                                          reset;
    glb_packet_pkg::wr_packet_t                    wr_packet;
    logic                                          cfg_pc_dma_mode;
    glb_packet_pkg::dma_pc_header_t                cfg_pc_dma_header;
    logic                                          pc_start_pulse;
    logic                                          pc_done_pulse;
    glb_packet_pkg::cgra_cfg_t                     cgra_cfg_mon;
    logic [glb_param_pkg::CGRA_CFG_ADDR_WIDTH-1:0] cfg_rd_addr;
    logic [glb_param_pkg::CGRA_CFG_DATA_WIDTH-1:0] cfg_rd_data;
    int                                            error_count;
    int                                            check_count;
    logic [31:0]                                   rng;

    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic step_rng();
        rng = xorshift32(rng);
    endtask

    task automatic wait_cycles(input int n);
        repeat (n) @(negedge clk);
    endtask

    // one-cycle start, sampled by the rising edge in between
    task automatic pulse_start();
        @(negedge clk);
        pc_start_pulse = 1'b1;
        @(negedge clk);
        pc_start_pulse = 1'b0;
    endtask

    // the watchdog bounds this loop
    task automatic wait_done();
        do begin
            @(negedge clk);
        end while (!pc_done_pulse);
    endtask

    task automatic load_bank();
        logic [31:0] hi;
        for (int i = 0; i < glb_param_pkg::BANK_DEPTH; i++) begin
            @(negedge clk);
            step_rng();
            hi = rng;
            step_rng();
            wr_packet.wr_en   = 1'b1;
            wr_packet.wr_addr = glb_param_pkg::GLB_ADDR_WIDTH'(i * 8);
            wr_packet.wr_data = {hi, rng};
        end
        @(negedge clk);
        wr_packet.wr_en = 1'b0;
    endtask

    task automatic run_transfer(input int idx);
        logic [7:0] word_idx;
        int         count;
        logic       mode;
        step_rng();
        word_idx = rng[7:0];
        step_rng();
        count = int'(rng % (MAX_CNT + 1));
        step_rng();
        mode = rng[0];
        // pin the zero-count and mode 0 cases early
        if (idx == 0) begin
            count = 0;
            mode  = 1'b1;
        end
        if (idx == 1) begin
            mode = 1'b0;
        end
        cfg_pc_dma_mode              = mode;
        cfg_pc_dma_header.start_addr = {word_idx, 3'b000};
        cfg_pc_dma_header.num_cfgs   = 8'(count);
        pulse_start();
        if (!mode) begin
            wait_cycles(QUIET_CYCLES);
        end else begin
            if (count >= 4) begin
                // second start mid-run with a fresh header, must be dropped
                wait_cycles(3);
                step_rng();
                cfg_pc_dma_header.start_addr = rng[10:0];
                cfg_pc_dma_header.num_cfgs   = rng[18:11];
                pulse_start();
            end
            wait_done();
        end
        wait_cycles(2);
    endtask

    task automatic read_back_regs();
        for (int i = 0; i < glb_param_pkg::CGRA_CFG_NUM_REGS; i++) begin
            @(negedge clk);
            cfg_rd_addr = glb_param_pkg::CGRA_CFG_ADDR_WIDTH'(i);
        end
        @(negedge clk);
    endtask

    glb_pc_top u_dut (
        .clk               (clk),
        .reset             (reset),
        .wr_packet         (wr_packet),
        .cfg_pc_dma_mode   (cfg_pc_dma_mode),
        .cfg_pc_dma_header (cfg_pc_dma_header),
        .pc_start_pulse    (pc_start_pulse),
        .pc_done_pulse     (pc_done_pulse),
        .cgra_cfg_mon      (cgra_cfg_mon),
        .cfg_rd_addr       (cfg_rd_addr),
        .cfg_rd_data       (cfg_rd_data)
    );

    pc_checker u_checker (
        .clk               (clk),
        .reset             (reset),
        .wr_packet         (wr_packet),
        .cfg_pc_dma_mode   (cfg_pc_dma_mode),
        .cfg_pc_dma_header (cfg_pc_dma_header),
        .pc_start_pulse    (pc_start_pulse),
        .pc_done_pulse     (pc_done_pulse),
        .cgra_cfg_mon      (cgra_cfg_mon),
        .cfg_rd_addr       (cfg_rd_addr),
        .cfg_rd_data       (cfg_rd_data),
        .error_count       (error_count),
        .check_count       (check_count)
    );

    initial begin
        rng               = 32'd4;
        reset             = 1'b1;
        wr_packet         = '0;
        cfg_pc_dma_mode   = 1'b0;
        cfg_pc_dma_header = '0;
        pc_start_pulse    = 1'b0;
        cfg_rd_addr       = '0;
        wait_cycles(RESET_CYCLES);
        reset = 1'b0;
        load_bank();
        for (int t = 0; t < NUM_XFERS; t++) begin
            run_transfer(t);
        end
        read_back_regs();
        wait_cycles(2);
        $display("checks %0d, errors %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

    // bounded by transfer count, bank load and readback
    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("timeout: run did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("Something failed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== all.f ====
source/glb_param_pkg.sv
source/glb_packet_pkg.sv
source/glb_shift.sv
source/glb_bank.sv
source/glb_pc_dma.sv
source/cgra_cfg_reg_file.sv
source/glb_pc_top.sv
testbench/pc_checker.sv
testbench/tb_glb_pc.sv

// ==== Makefile ====
LOG := sim.log

.PHONY: sim clean

sim:
	verilator --binary --timing -f all.f --top-module tb_glb_pc -o tb_glb_pc
	./obj_dir/tb_glb_pc | tee $(LOG)
	grep -q "^Everything OK$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
